/* verilog/fetch_pkg.sv */
// Fetch address types, reset vector and pair helpers; import into any fetch-side module
package fetch_pkg;

	// --------------------------------------------------
	// Addressing
	// --------------------------------------------------

	// PC bits 31:2, one instruction word per step
	typedef logic [29:0] word_addr_t;

	// Boot address of the core
	localparam logic [31:0] RESET_PC = 32'h1c00_0000;

	// --------------------------------------------------
	// Fetch pair helpers
	// --------------------------------------------------

	// Sequential successor of an aligned slot pair
	function automatic word_addr_t pair_next(input word_addr_t addr);
		word_addr_t pair_base;
		pair_base = {addr[29:1], 1'b0};
		return pair_base + 30'd2;
	endfunction

endpackage : fetch_pkg

/* verilog/bpu_pkg.sv */
// Branch types, return stack constants and the update/prediction words of the predictor
package bpu_pkg;

	// --------------------------------------------------
	// Branch classification
	// --------------------------------------------------

	// Only BR_COND consults the counter tables
	typedef enum logic [1:0] {
		BR_COND   = 2'd0,
		BR_JUMP   = 2'd1,
		BR_CALL   = 2'd2,
		BR_RETURN = 2'd3
	} br_type_e;

	// --------------------------------------------------
	// Return address stack
	// --------------------------------------------------

	localparam int RAS_DEPTH = 8;
	localparam int RAS_PTR_W = 3;

	// --------------------------------------------------
	// Training / redirect word from decoder or executor
	// --------------------------------------------------

	typedef struct packed {
		logic                  flush;
		logic [31:0]           br_target;
		fetch_pkg::word_addr_t pc;
		logic                  btb_update;
		br_type_e              br_type;
		logic                  lpht_update;
		logic                  br_taken;
		logic [1:0]            lphr;          // counter value seen at predict time
		logic                  ras_redirect;
		logic [RAS_PTR_W-1:0]  ras_ptr;
	} bpu_update_t;

	// Prediction that travels with the fetch pair
	typedef struct packed {
		logic                  fsc;
		logic                  taken;
		fetch_pkg::word_addr_t npc;
		logic [1:0]            lphr;
		logic [RAS_PTR_W-1:0]  ras_ptr;
		br_type_e              br_type;
	} bpu_predict_t;

endpackage : bpu_pkg

/* verilog/btb.sv */
// Two-bank tagged branch target buffer, one cycle read; instantiated by the predictor top
`timescale 1ns/100ps

module btb #(
	parameter int BTB_ADDR_WIDTH = 6
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  fetch_pkg::word_addr_t rpc_i,
	input  logic                  update_i,
	input  fetch_pkg::word_addr_t wpc_i,
	input  fetch_pkg::word_addr_t bta_i,
	input  bpu_pkg::br_type_e     br_type_i,
	output fetch_pkg::word_addr_t bta_o [2],
	output bpu_pkg::br_type_e     br_type_o [2]
);
	import fetch_pkg::*;
	import bpu_pkg::*;

	localparam int DEPTH   = 1 << BTB_ADDR_WIDTH;
	localparam int TAG_W   = 8;
	localparam int TAG_LSB = BTB_ADDR_WIDTH + 1;

	logic [DEPTH-1:0]          valid_q [2];
	logic [TAG_W-1:0]          tag_q [2][DEPTH];
	word_addr_t                bta_q [2][DEPTH];
	br_type_e                  type_q [2][DEPTH];
	logic [BTB_ADDR_WIDTH-1:0] ridx;
	logic [BTB_ADDR_WIDTH-1:0] widx;
	logic [TAG_W-1:0]          rtag;
	logic                      wbank;
	logic [1:0]                hit_q;
	word_addr_t                bta_rd_q [2];
	br_type_e                  type_rd_q [2];

	// Bit 0 of the word address picks the bank
	assign ridx  = rpc_i[BTB_ADDR_WIDTH:1];
	assign rtag  = rpc_i[TAG_LSB +: TAG_W];
	assign widx  = wpc_i[BTB_ADDR_WIDTH:1];
	assign wbank = wpc_i[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
		end else if (update_i) begin
			valid_q[wbank][widx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update_i) begin
			tag_q[wbank][widx]  <= wpc_i[TAG_LSB +: TAG_W];
			bta_q[wbank][widx]  <= bta_i;
			type_q[wbank][widx] <= br_type_i;
		end
	end

	// --------------------------------------------------
	// Registered lookup
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hit_q <= '0;
		end else begin
			for (int b = 0; b < 2; b++) begin
				hit_q[b] <= valid_q[b][ridx] && (tag_q[b][ridx] == rtag);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int b = 0; b < 2; b++) begin
			bta_rd_q[b]  <= bta_q[b][ridx];
			type_rd_q[b] <= type_q[b][ridx];
		end
	end

	// Miss looks like a plain conditional with no target
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			bta_o[b]     = hit_q[b] ? bta_rd_q[b] : '0;
			br_type_o[b] = hit_q[b] ? type_rd_q[b] : BR_COND;
		end
	end

endmodule : btb

/* verilog/pht.sv */
// One bank of 2-bit saturating taken counters with registered read; two used by the predictor
`timescale 1ns/100ps

module pht #(
	parameter int LPHT_ADDR_WIDTH = 7
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       we_i,
	input  logic                       taken_i,
	input  logic [1:0]                 phr_i,
	input  logic [LPHT_ADDR_WIDTH-1:0] rindex_i,
	input  logic [LPHT_ADDR_WIDTH-1:0] windex_i,
	output logic [1:0]                 phr_o
);
	localparam int DEPTH = 1 << LPHT_ADDR_WIDTH;

	logic [1:0] cnt_q [DEPTH];
	logic [1:0] cnt_next;

	// Saturating step from the value seen at predict time
	always_comb begin
		cnt_next = phr_i;
		if (taken_i && (phr_i != 2'b11)) begin
			cnt_next = phr_i + 2'd1;
		end else if (!taken_i && (phr_i != 2'b00)) begin
			cnt_next = phr_i - 2'd1;
		end
	end

	// Weakly not-taken after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				cnt_q[i] <= 2'b01;
			end
			phr_o <= 2'b01;
		end else begin
			if (we_i) begin
				cnt_q[windex_i] <= cnt_next;
			end
			phr_o <= cnt_q[rindex_i];
		end
	end

endmodule : pht

/* verilog/ras.sv */
// Circular return address stack with pointer restore; used by the predictor for returns
`timescale 1ns/100ps

module ras (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          push_i,
	input  logic                          pop_i,
	input  logic                          redirect_i,
	input  logic [bpu_pkg::RAS_PTR_W-1:0] stack_ptr_i,
	input  fetch_pkg::word_addr_t         target_i,
	input  fetch_pkg::word_addr_t         redirect_target_i,
	output fetch_pkg::word_addr_t         target_o,
	output logic [bpu_pkg::RAS_PTR_W-1:0] stack_ptr_o
);
	import fetch_pkg::*;
	import bpu_pkg::*;

	word_addr_t           stack_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] ptr_q;
	logic [RAS_PTR_W-1:0] ptr_inc;
	logic [RAS_PTR_W-1:0] ptr_dec;

	// Pointer wraps, oldest entries are overwritten
	assign ptr_inc = ptr_q + 1'b1;
	assign ptr_dec = ptr_q - 1'b1;

	// Redirect beats push and pop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (redirect_i) begin
			ptr_q <= stack_ptr_i;
		end else if (push_i) begin
			ptr_q <= ptr_inc;
		end else if (pop_i) begin
			ptr_q <= ptr_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_i) begin
			stack_q[stack_ptr_i] <= redirect_target_i;
		end else if (push_i) begin
			stack_q[ptr_inc] <= target_i;
		end
	end

	// Top of stack straight from the registers
	assign target_o    = stack_q[ptr_q];
	assign stack_ptr_o = ptr_q;

endmodule : ras

/* verilog/bpu.sv */
// Branch predictor top for the dual-issue fetch stage; drives fetch PC, slot valids and prediction
`timescale 1ns/100ps

module bpu #(
	parameter int BTB_ADDR_WIDTH  = 6,
	parameter int LPHT_ADDR_WIDTH = 7
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  bpu_pkg::bpu_update_t  update_front_i,
	input  bpu_pkg::bpu_update_t  update_back_i,
	output bpu_pkg::bpu_predict_t predict_o,
	output logic [31:0]           pc_o,
	output logic [1:0]            pc_valid_o,
	output logic                  stall_o
);
	import fetch_pkg::*;
	import bpu_pkg::*;

	bpu_update_t          upd;
	word_addr_t           pc_q;
	logic                 refill_q;
	word_addr_t           npc;
	word_addr_t           ppc;
	word_addr_t           btb_bta [2];
	br_type_e             btb_type [2];
	logic [1:0]           lphr [2];
	word_addr_t           ras_target;
	logic [RAS_PTR_W-1:0] ras_ptr;
	logic                 taken0;
	logic                 taken1;
	logic                 taken;
	logic                 fsc;
	br_type_e             sel_type;
	logic                 fetch_go;

	// --------------------------------------------------
	// Update merge, back end has priority
	// --------------------------------------------------
	always_comb begin
		upd = update_back_i;
		if (!update_back_i.flush && update_front_i.flush) begin
			upd = update_front_i;
		end
	end

	// --------------------------------------------------
	// PC and refill state
	// --------------------------------------------------

	// One bubble after any flush while the tables catch up
	always_ff @(posedge clk) begin
		if (!rst_n || upd.flush) begin
			refill_q <= 1'b1;
		end else begin
			refill_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= RESET_PC[31:2];
		end else if (upd.flush) begin
			pc_q <= upd.br_target[31:2];
		end else if (!stall_i) begin
			pc_q <= npc;
		end
	end

	// Re-read the current pair while holding
	assign npc = (refill_q || stall_i) ? pc_q : ppc;

	// --------------------------------------------------
	// Lookup tables
	// --------------------------------------------------
	btb #(
		.BTB_ADDR_WIDTH(BTB_ADDR_WIDTH)
	) u_btb (
		.clk       (clk),
		.rst_n     (rst_n),
		.rpc_i     (npc),
		.update_i  (upd.btb_update),
		.wpc_i     (upd.pc),
		.bta_i     (upd.br_target[31:2]),
		.br_type_i (upd.br_type),
		.bta_o     (btb_bta),
		.br_type_o (btb_type)
	);

	for (genvar b = 0; b < 2; b++) begin : g_pht
		pht #(
			.LPHT_ADDR_WIDTH(LPHT_ADDR_WIDTH)
		) u_pht (
			.clk      (clk),
			.rst_n    (rst_n),
			.we_i     (upd.lpht_update && (upd.pc[0] == 1'(b))),
			.taken_i  (upd.br_taken),
			.phr_i    (upd.lphr),
			.rindex_i (npc[LPHT_ADDR_WIDTH:1]),
			.windex_i (upd.pc[LPHT_ADDR_WIDTH:1]),
			.phr_o    (lphr[b])
		);
	end

	// Stack only moves on a real fetch
	assign fetch_go = !stall_i && !refill_q;

	ras u_ras (
		.clk               (clk),
		.rst_n             (rst_n),
		.push_i            (fetch_go && (sel_type == BR_CALL)),
		.pop_i             (fetch_go && (sel_type == BR_RETURN)),
		.redirect_i        (upd.ras_redirect),
		.stack_ptr_i       (upd.ras_ptr),
		.target_i          ({pc_q[29:1], fsc} + 30'd1),
		.redirect_target_i (upd.pc + 30'd1),
		.target_o          (ras_target),
		.stack_ptr_o       (ras_ptr)
	);

	// --------------------------------------------------
	// Slot selection and next PC
	// --------------------------------------------------

	// Slot 0 exists only for an aligned pair
	assign taken0   = !pc_q[0] && ((btb_type[0] != BR_COND) || lphr[0][1]);
	assign taken1   = (btb_type[1] != BR_COND) || lphr[1][1];
	assign fsc      = !taken0;
	assign taken    = taken0 || taken1;
	assign sel_type = btb_type[fsc];

	assign ppc = (sel_type == BR_RETURN) ? ras_target :
	             taken ? btb_bta[fsc] : pair_next(pc_q);

	assign pc_o          = {pc_q, 2'b00};
	assign stall_o       = refill_q;
	assign pc_valid_o[0] = !pc_q[0] && !stall_o && !stall_i;
	assign pc_valid_o[1] = !taken0 && !stall_o && !stall_i;

	always_comb begin
		predict_o.fsc     = fsc;
		predict_o.taken   = taken;
		predict_o.npc     = npc;
		predict_o.lphr    = lphr[fsc];
		predict_o.ras_ptr = ras_ptr;
		predict_o.br_type = sel_type;
	end

endmodule : bpu

/* verif/bpu_sva.sv */
// Concurrent timing checks on the predictor top; attached to every bpu instance by bind
`timescale 1ns/100ps

module bpu_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 stall_i,
	input bpu_pkg::bpu_update_t update_front_i,
	input bpu_pkg::bpu_update_t update_back_i,
	input logic [31:0]          pc_o,
	input logic [1:0]           pc_valid_o,
	input logic                 stall_o
);
	logic flush;

	// Either source can redirect fetch
	assign flush = update_front_i.flush || update_back_i.flush;

	// --------------------------------------------------
	// Refill bubble and hold rules
	// --------------------------------------------------
	a_flush_refill: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> stall_o)
		else $error("stall_o did not rise after a flush");

	a_refill_once: assert property (@(posedge clk) disable iff (!rst_n)
		!flush |=> !stall_o)
		else $error("stall_o stayed high longer than one cycle after a flush");

	a_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(stall_i || stall_o) |-> (pc_valid_o == 2'b00))
		else $error("pc_valid_o set while fetch is stalled");

	a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(stall_i && !flush) |=> $stable(pc_o))
		else $error("pc_o moved under stall_i without a flush");

endmodule : bpu_sva

bind bpu bpu_sva u_bpu_sva (
	.clk            (clk),
	.rst_n          (rst_n),
	.stall_i        (stall_i),
	.update_front_i (update_front_i),
	.update_back_i  (update_back_i),
	.pc_o           (pc_o),
	.pc_valid_o     (pc_valid_o),
	.stall_o        (stall_o)
);

/* verif/bpu_tb.sv */
// Self-checking testbench for the predictor top; run from sim.f with the reference model below
`timescale 1ns/100ps

module bpu_tb;
	import fetch_pkg::*;
	import bpu_pkg::*;

	localparam int BTB_W           = 6;
	localparam int LPHT_W          = 7;
	localparam int RESET_CYCLES    = 3;
	localparam int DIRECTED_CYCLES = 50;
	localparam int RANDOM_CYCLES   = 40;
	localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
	localparam logic [15:0] LFSR_SEED = 16'd53574;

	logic         clk;
	logic         rst_n;
	logic         stall_i;
	bpu_update_t  upd_front;
	bpu_update_t  upd_back;
	bpu_predict_t predict;
	logic [31:0]  pc;
	logic [1:0]   pc_valid;
	logic         stall;
	logic [15:0]  lfsr;
	logic         model_ready = 1'b0;

	// Reference model state
	word_addr_t           m_pc;
	logic                 m_refill;
	logic                 bt_vld [2][1 << BTB_W];
	word_addr_t           bt_pc  [2][1 << BTB_W];
	word_addr_t           bt_tgt [2][1 << BTB_W];
	br_type_e             bt_typ [2][1 << BTB_W];
	logic [1:0]           ctr    [2][1 << LPHT_W];
	word_addr_t           stk    [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] sp;
	br_type_e             s_typ [2];
	word_addr_t           s_tgt [2];
	logic [1:0]           s_ctr [2];
	logic                 e_taken0;
	logic                 e_taken1;
	logic                 e_fsc;
	br_type_e             e_sel;
	word_addr_t           e_npc;
	logic [1:0]           e_valid;

	bpu #(
		.BTB_ADDR_WIDTH  (BTB_W),
		.LPHT_ADDR_WIDTH (LPHT_W)
	) UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.stall_i        (stall_i),
		.update_front_i (upd_front),
		.update_back_i  (upd_back),
		.predict_o      (predict),
		.pc_o           (pc),
		.pc_valid_o     (pc_valid),
		.stall_o        (stall)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(TEST_CYCLES * 8 + 100);
		abort_run("Watchdog expired before the test sequence finished");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		abort_run($sformatf("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, got));
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit drawn
	task automatic draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [1:0] counter_step(input logic [1:0] old, input logic taken);
		if (taken) begin
			return (old == 2'b11) ? old : old + 2'd1;
		end
		return (old == 2'b00) ? old : old - 2'd1;
	endfunction

	function automatic bpu_update_t flush_word(input logic [31:0] target);
		bpu_update_t u;
		u           = '0;
		u.flush     = 1'b1;
		u.br_target = target;
		return u;
	endfunction

	function automatic bpu_update_t btb_word(input logic [31:0] slot, input logic [31:0] target,
			input br_type_e kind);
		bpu_update_t u;
		u            = '0;
		u.btb_update = 1'b1;
		u.pc         = slot[31:2];
		u.br_target  = target;
		u.br_type    = kind;
		return u;
	endfunction

	function automatic bpu_update_t counter_word(input logic [31:0] slot, input logic [1:0] old,
			input logic taken);
		bpu_update_t u;
		u             = '0;
		u.lpht_update = 1'b1;
		u.pc          = slot[31:2];
		u.lphr        = old;
		u.br_taken    = taken;
		return u;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Present one update pair for a single cycle
	task automatic send_updates(input bpu_update_t front, input bpu_update_t back);
		upd_front = front;
		upd_back  = back;
		next_cycle();
		upd_front = '0;
		upd_back  = '0;
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	always_comb begin
		e_taken0 = !m_pc[0] && ((s_typ[0] != BR_COND) || s_ctr[0][1]);
		e_taken1 = (s_typ[1] != BR_COND) || s_ctr[1][1];
		e_fsc    = !e_taken0;
		e_sel    = s_typ[e_fsc];
		if (m_refill || stall_i) begin
			e_npc = m_pc;
		end else if (e_sel == BR_RETURN) begin
			e_npc = stk[sp];
		end else if (e_taken0 || e_taken1) begin
			e_npc = s_tgt[e_fsc];
		end else begin
			e_npc = {m_pc[29:1], 1'b0} + 30'd2;
		end
		e_valid = {!e_taken0, !m_pc[0]} & {2{!m_refill && !stall_i}};
	end

	always @(posedge clk) begin : model_step
		bpu_update_t          u;
		logic                 go;
		logic [RAS_PTR_W-1:0] sp_up;
		u     = (!upd_back.flush && upd_front.flush) ? upd_front : upd_back;
		go    = !stall_i && !m_refill;
		sp_up = sp + 1'b1;
		model_ready <= 1'b1;
		if (!rst_n) begin
			m_pc     <= RESET_PC[31:2];
			m_refill <= 1'b1;
			sp       <= '0;
			for (int b = 0; b < 2; b++) begin
				s_typ[b] <= BR_COND;
				s_tgt[b] <= '0;
				s_ctr[b] <= 2'b01;
				for (int i = 0; i < (1 << BTB_W); i++) begin
					bt_vld[b][i] <= 1'b0;
				end
				for (int i = 0; i < (1 << LPHT_W); i++) begin
					ctr[b][i] <= 2'b01;
				end
			end
		end else begin
			// Lookup sees the tables as they were before this edge
			for (int b = 0; b < 2; b++) begin
				if (bt_vld[b][e_npc[BTB_W:1]] &&
						(bt_pc[b][e_npc[BTB_W:1]][29:1] == e_npc[29:1])) begin
					s_typ[b] <= bt_typ[b][e_npc[BTB_W:1]];
					s_tgt[b] <= bt_tgt[b][e_npc[BTB_W:1]];
				end else begin
					s_typ[b] <= BR_COND;
					s_tgt[b] <= '0;
				end
				s_ctr[b] <= ctr[b][e_npc[LPHT_W:1]];
			end
			if (u.btb_update) begin
				bt_vld[u.pc[0]][u.pc[BTB_W:1]] <= 1'b1;
				bt_pc[u.pc[0]][u.pc[BTB_W:1]]  <= u.pc;
				bt_tgt[u.pc[0]][u.pc[BTB_W:1]] <= u.br_target[31:2];
				bt_typ[u.pc[0]][u.pc[BTB_W:1]] <= u.br_type;
			end
			if (u.lpht_update) begin
				ctr[u.pc[0]][u.pc[LPHT_W:1]] <= counter_step(u.lphr, u.br_taken);
			end
			if (u.ras_redirect) begin
				sp             <= u.ras_ptr;
				stk[u.ras_ptr] <= u.pc + 30'd1;
			end else if (go && (e_sel == BR_CALL)) begin
				sp         <= sp_up;
				stk[sp_up] <= {m_pc[29:1], e_fsc} + 30'd1;
			end else if (go && (e_sel == BR_RETURN)) begin
				sp <= sp - 1'b1;
			end
			if (u.flush) begin
				m_pc <= u.br_target[31:2];
			end else if (!stall_i) begin
				m_pc <= e_npc;
			end
			m_refill <= u.flush;
		end
	end

	// Outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (model_ready) begin
			assert (pc === {m_pc, 2'b00})
				else report_mismatch("pc_o", {m_pc, 2'b00}, pc);
			assert (stall === m_refill)
				else report_mismatch("stall_o", 32'(m_refill), 32'(stall));
			assert (pc_valid === e_valid)
				else report_mismatch("pc_valid_o", 32'(e_valid), 32'(pc_valid));
			assert (predict.taken === (e_taken0 || e_taken1))
				else report_mismatch("predict_o.taken", 32'(e_taken0 || e_taken1),
					32'(predict.taken));
			assert (predict.fsc === e_fsc)
				else report_mismatch("predict_o.fsc", 32'(e_fsc), 32'(predict.fsc));
			assert (predict.br_type === e_sel)
				else report_mismatch("predict_o.br_type", 32'(e_sel), 32'(predict.br_type));
			assert (predict.npc === e_npc)
				else report_mismatch("predict_o.npc", 32'(e_npc), 32'(predict.npc));
			assert (predict.lphr === s_ctr[e_fsc])
				else report_mismatch("predict_o.lphr", 32'(s_ctr[e_fsc]), 32'(predict.lphr));
			assert (predict.ras_ptr === sp)
				else report_mismatch("predict_o.ras_ptr", 32'(sp), 32'(predict.ras_ptr));
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		logic [15:0] r;
		logic [31:0] jump_pc;
		bpu_update_t u;
		lfsr      = LFSR_SEED;
		rst_n     = 1'b0;
		stall_i   = 1'b0;
		upd_front = '0;
		upd_back  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;

		// Empty tables, then a flush onto the odd slot of a pair
		repeat (6) next_cycle();
		send_updates('0, flush_word(32'h1c00_0104));
		repeat (4) next_cycle();

		// Back word wins over front word
		send_updates(flush_word(32'h1c00_0200), flush_word(32'h1c00_0300));
		repeat (3) next_cycle();
		send_updates(flush_word(32'h1c00_0600), '0);
		repeat (3) next_cycle();

		// Roughly one stall in four
		repeat (RANDOM_CYCLES) begin
			draw_bits(2, r);
			stall_i = (r[1:0] == 2'b00);
			next_cycle();
		end
		stall_i = 1'b0;

		// Jump in slot 0 of a random pair
		draw_bits(5, r);
		jump_pc = 32'h1c00_0400 + {r[4:0], 3'b000};
		send_updates('0, btb_word(jump_pc, 32'h1c00_0800, BR_JUMP));
		send_updates('0, flush_word(jump_pc));
		repeat (4) next_cycle();

		// Conditional in slot 1 turns taken, then back to weakly not-taken
		send_updates('0, btb_word(32'h1c00_0704, 32'h1c00_0880, BR_COND));
		send_updates('0, counter_word(32'h1c00_0704, 2'b01, 1'b1));
		send_updates('0, counter_word(32'h1c00_0704, 2'b10, 1'b1));
		send_updates('0, flush_word(32'h1c00_0700));
		repeat (4) next_cycle();
		send_updates('0, counter_word(32'h1c00_0704, 2'b11, 1'b0));
		send_updates('0, counter_word(32'h1c00_0704, 2'b10, 1'b0));

		// Call in slot 1, return at the callee entry
		send_updates('0, btb_word(32'h1c00_0914, 32'h1c00_0a00, BR_CALL));
		send_updates('0, btb_word(32'h1c00_0a00, 32'h0000_0000, BR_RETURN));
		send_updates('0, flush_word(32'h1c00_0910));
		repeat (5) next_cycle();

		// Stack restore from the call slot, then replay the return
		u              = flush_word(32'h1c00_0a00);
		u.ras_redirect = 1'b1;
		u.ras_ptr      = 3'd5;
		u.pc           = 30'h0700_0245;
		send_updates('0, u);
		repeat (5) next_cycle();

		$display("Test OK");
		$finish;
	end

endmodule : bpu_tb

/* sim.f */
verilog/fetch_pkg.sv
verilog/bpu_pkg.sv
verilog/btb.sv
verilog/pht.sv
verilog/ras.sv
verilog/bpu.sv
verif/bpu_sva.sv
verif/bpu_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module bpu_tb -f sim.f -o Vbpu_tb \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vbpu_tb > sim.log 2>&1
grep -q "Test FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"
